/* src/core_pkg.sv */
package core_pkg;

    // architectural register file size
    localparam int NUM_REGS = 32;

    typedef logic [31:0] word_t;

    // register 0 reads as zero and is never marked pending
    typedef logic [4:0] reg_addr_t;

    // operation class, only what issue needs to see
    typedef enum logic [3:0] {
        ALU    = 4'd0,
        MULT   = 4'd1,
        DIV    = 4'd2,
        MFHI   = 4'd3,
        MFLO   = 4'd4,
        MTHI   = 4'd5,
        MTLO   = 4'd6,
        BRANCH = 4'd7,
        JUMP   = 4'd8
    } op_t;

    // control bits from decode
    // hitoreg / lotoreg mark a read of hi / lo into the gpr file
    typedef struct packed {
        op_t  op;
        logic regwrite;
        logic hiwrite;
        logic lowrite;
        logic hitoreg;
        logic lotoreg;
        logic branch;
        logic jump;
    } ctl_t;

    // one decoded instruction as it sits in the queue
    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     raw_instr;
        word_t     imm;
        reg_addr_t ra1;
        reg_addr_t ra2;
        reg_addr_t rdst;
        ctl_t      ctl;
    } decode_data_t;

    // one issued instruction, sources replaced by operand values
    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     raw_instr;
        word_t     imm;
        reg_addr_t rdst;
        ctl_t      ctl;
        word_t     rd1;
        word_t     rd2;
        // set on the instruction in a branch delay slot
        logic      is_slot;
    } issue_data_t;

endpackage

/* src/issue_pkg.sv */
package issue_pkg;

    // instructions per cycle in and out
    localparam int ISSUE_WIDTH = 2;

    // total entries, split evenly over two banks
    localparam int QUEUE_DEPTH = 16;
    localparam int BANK_DEPTH  = QUEUE_DEPTH / 2;

    // global pointer width, lsb selects the bank
    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    // two source reads per issue slot
    localparam int READ_PORTS = 2 * ISSUE_WIDTH;

    // writeback ports into the register file
    localparam int WB_PORTS = 2;

    // row inside one bank
    typedef logic [2:0] bank_idx_t;

    // occupancy, 0 to QUEUE_DEPTH inclusive
    typedef logic [4:0] count_t;

    // global queue position
    typedef logic [PTR_W-1:0] ptr_t;

    // number popped in one cycle, 0 to ISSUE_WIDTH
    typedef logic [$clog2(ISSUE_WIDTH+1)-1:0] pop_cnt_t;

endpackage

/* src/issue_if.sv */
`timescale 1ns/1ps

// decode pair into the queue
interface decode_if;
    import core_pkg::*;
    import issue_pkg::*;

    // slot 0 older, valid[1] only together with valid[0]
    logic [ISSUE_WIDTH-1:0] valid;
    decode_data_t           data [ISSUE_WIDTH];
    // at least two free entries
    logic                   ready;
    logic                   flush;

    modport src (output valid, output data, output flush, input ready);
    modport dst (input valid, input data, input flush, output ready);
endinterface

// two oldest queue entries toward the selector
interface head_if;
    import core_pkg::*;
    import issue_pkg::*;

    logic [ISSUE_WIDTH-1:0] head_valid;
    decode_data_t           head [ISSUE_WIDTH];
    // entries leaving the head this cycle
    pop_cnt_t               pop_count;
    logic                   flush;

    modport queue  (output head_valid, output head, input pop_count, input flush);
    modport select (input head_valid, input head, output pop_count, input flush);
endinterface

/* src/issue_queue.sv */
`timescale 1ns/1ps

module issue_queue (
    input  logic  clk,
    input  logic  arst_n,
    decode_if.dst dec,
    head_if.queue hd
);
    import core_pkg::*;
    import issue_pkg::*;

    // even bank holds global positions 0,2,4..; odd bank 1,3,5..
    decode_data_t even_bank [BANK_DEPTH];
    decode_data_t odd_bank  [BANK_DEPTH];

    ptr_t   head_ptr;
    ptr_t   tail_ptr;
    ptr_t   head_p1;
    ptr_t   tail_p1;
    count_t count;

    logic         push;
    count_t       push_n;
    logic         even_we;
    logic         odd_we;
    bank_idx_t    even_row;
    bank_idx_t    odd_row;
    decode_data_t even_wdata;
    decode_data_t odd_wdata;

    assign head_p1 = head_ptr + 1'b1;
    assign tail_p1 = tail_ptr + 1'b1;

    // pair accepted whenever ready, dropped on flush
    assign push   = dec.ready & dec.valid[0] & ~dec.flush;
    assign push_n = push ? count_t'(dec.valid[0]) + count_t'(dec.valid[1]) : '0;

    // older slot lands in the bank picked by the tail lsb
    always_comb begin
        if (!tail_ptr[0]) begin
            even_we    = push;
            even_row   = tail_ptr[PTR_W-1:1];
            even_wdata = dec.data[0];
            odd_we     = push & dec.valid[1];
            odd_row    = tail_p1[PTR_W-1:1];
            odd_wdata  = dec.data[1];
        end else begin
            odd_we     = push;
            odd_row    = tail_ptr[PTR_W-1:1];
            odd_wdata  = dec.data[0];
            even_we    = push & dec.valid[1];
            even_row   = tail_p1[PTR_W-1:1];
            even_wdata = dec.data[1];
        end
    end

    // one write port per bank
    always_ff @(posedge clk) begin
        if (even_we) begin
            even_bank[even_row] <= even_wdata;
        end
        if (odd_we) begin
            odd_bank[odd_row] <= odd_wdata;
        end
    end

    // one read port per bank, oldest first
    always_comb begin
        if (!head_ptr[0]) begin
            hd.head[0] = even_bank[head_ptr[PTR_W-1:1]];
            hd.head[1] = odd_bank[head_p1[PTR_W-1:1]];
        end else begin
            hd.head[0] = odd_bank[head_ptr[PTR_W-1:1]];
            hd.head[1] = even_bank[head_p1[PTR_W-1:1]];
        end
    end

    assign hd.head_valid[0] = (count != '0);
    assign hd.head_valid[1] = (count > count_t'(1));

    // room for a full pair
    assign dec.ready = (count_t'(QUEUE_DEPTH) - count) >= count_t'(ISSUE_WIDTH);

    // pointers wrap naturally at QUEUE_DEPTH
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else if (dec.flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            head_ptr <= head_ptr + ptr_t'(hd.pop_count);
            tail_ptr <= tail_ptr + ptr_t'(push_n);
            count    <= count + push_n - count_t'(hd.pop_count);
        end
    end

endmodule

/* src/issue_select.sv */
`timescale 1ns/1ps

module issue_select (
    input  logic                               clk,
    input  logic                               arst_n,
    head_if.select                             hd,
    input  logic                               stall,
    output core_pkg::reg_addr_t                rf_raddr [issue_pkg::READ_PORTS],
    input  core_pkg::word_t                    rf_rdata [issue_pkg::READ_PORTS],
    input  logic [issue_pkg::READ_PORTS-1:0]   rf_ready,
    output logic [issue_pkg::ISSUE_WIDTH-1:0]  set_en,
    output core_pkg::reg_addr_t                set_addr [issue_pkg::ISSUE_WIDTH],
    output logic [issue_pkg::ISSUE_WIDTH-1:0]  iss_valid,
    output core_pkg::issue_data_t              iss_data [issue_pkg::ISSUE_WIDTH]
);
    import core_pkg::*;
    import issue_pkg::*;

    // i0 older, i1 younger
    decode_data_t i0;
    decode_data_t i1;

    logic [ISSUE_WIDTH-1:0] ops_ready;
    logic [ISSUE_WIDTH-1:0] go;
    logic                   br0;
    logic                   br1;
    logic                   raw_dep;
    logic                   muldiv_pair;
    logic                   hilo_dep;
    logic                   pair_ok;
    issue_data_t            rec [ISSUE_WIDTH];

    function automatic logic is_muldiv(input op_t op);
        return (op == MULT) || (op == DIV);
    endfunction

    assign i0 = hd.head[0];
    assign i1 = hd.head[1];

    // ra1 on even read ports, ra2 on odd
    always_comb begin
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            rf_raddr[2*s]   = hd.head[s].ra1;
            rf_raddr[2*s+1] = hd.head[s].ra2;
            ops_ready[s]    = rf_ready[2*s] & rf_ready[2*s+1];
        end
    end

    assign br0 = i0.ctl.branch | i0.ctl.jump;
    assign br1 = i1.ctl.branch | i1.ctl.jump;

    // younger reads older's result, r0 carries no dependency
    assign raw_dep = i0.ctl.regwrite && (i0.rdst != '0)
                     && ((i0.rdst == i1.ra1) || (i0.rdst == i1.ra2));

    // single mul/div unit
    assign muldiv_pair = is_muldiv(i0.ctl.op) && is_muldiv(i1.ctl.op);

    assign hilo_dep = (i0.ctl.hiwrite && i1.ctl.hitoreg)
                      || (i0.ctl.lowrite && i1.ctl.lotoreg);

    // a delay slot may read the link register of its branch
    assign pair_ok = hd.head_valid[1] && ops_ready[1]
                     && !(raw_dep && !br0)
                     && !muldiv_pair
                     && !hilo_dep
                     && !br1;

    // branch waits until its slot can go with it
    assign go[0] = hd.head_valid[0] && ops_ready[0] && !stall && !hd.flush
                   && (!br0 || pair_ok);
    assign go[1] = go[0] && pair_ok;

    assign hd.pop_count = pop_cnt_t'(go[0]) + pop_cnt_t'(go[1]);

    // scoreboard marks destinations of what leaves now
    always_comb begin
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            set_en[s]   = go[s] && hd.head[s].ctl.regwrite && (hd.head[s].rdst != '0);
            set_addr[s] = hd.head[s].rdst;
        end
    end

    // issued records with operand values
    always_comb begin
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            rec[s].valid     = go[s];
            rec[s].pc        = hd.head[s].pc;
            rec[s].raw_instr = hd.head[s].raw_instr;
            rec[s].imm       = hd.head[s].imm;
            rec[s].rdst      = hd.head[s].rdst;
            rec[s].ctl       = hd.head[s].ctl;
            rec[s].rd1       = rf_rdata[2*s];
            rec[s].rd2       = rf_rdata[2*s+1];
            rec[s].is_slot   = 1'b0;
        end
        // slot 1 behind a branch is its delay slot
        rec[1].is_slot = br0;
    end

    // holds during stall, clears on flush
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            iss_valid <= '0;
        end else if (hd.flush) begin
            iss_valid <= '0;
        end else if (!stall) begin
            iss_valid <= go;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            iss_data <= rec;
        end
    end

endmodule

/* src/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                              clk,
    input  logic                              arst_n,
    input  core_pkg::reg_addr_t               raddr [issue_pkg::READ_PORTS],
    output core_pkg::word_t                   rdata [issue_pkg::READ_PORTS],
    output logic [issue_pkg::READ_PORTS-1:0]  ready,
    input  logic [issue_pkg::WB_PORTS-1:0]    wb_en,
    input  core_pkg::reg_addr_t               wb_addr [issue_pkg::WB_PORTS],
    input  core_pkg::word_t                   wb_data [issue_pkg::WB_PORTS],
    input  logic [issue_pkg::ISSUE_WIDTH-1:0] set_en,
    input  core_pkg::reg_addr_t               set_addr [issue_pkg::ISSUE_WIDTH],
    input  logic                              flush
);
    import core_pkg::*;
    import issue_pkg::*;

    word_t                regs [NUM_REGS];
    logic [NUM_REGS-1:0]  pending;
    logic [NUM_REGS-1:0]  set_mask;
    logic [NUM_REGS-1:0]  clr_mask;

    // write-through, later port overrides so port 1 wins
    always_comb begin
        for (int r = 0; r < READ_PORTS; r++) begin
            rdata[r] = regs[raddr[r]];
            ready[r] = !pending[raddr[r]];
            for (int p = 0; p < WB_PORTS; p++) begin
                if (wb_en[p] && (wb_addr[p] == raddr[r])) begin
                    rdata[r] = wb_data[p];
                    ready[r] = 1'b1;
                end
            end
            // hardwired zero
            if (raddr[r] == '0) begin
                rdata[r] = '0;
                ready[r] = 1'b1;
            end
        end
    end

    // port 1 written last, wins on same address
    always_ff @(posedge clk) begin
        for (int p = 0; p < WB_PORTS; p++) begin
            if (wb_en[p] && (wb_addr[p] != '0)) begin
                regs[wb_addr[p]] <= wb_data[p];
            end
        end
    end

    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        for (int p = 0; p < WB_PORTS; p++) begin
            if (wb_en[p]) begin
                clr_mask[wb_addr[p]] = 1'b1;
            end
        end
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            if (set_en[s]) begin
                set_mask[set_addr[s]] = 1'b1;
            end
        end
        // r0 never pending
        set_mask[0] = 1'b0;
    end

    // set beats clear in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= '0;
        end else if (flush) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clr_mask) | set_mask;
        end
    end

endmodule

/* src/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [issue_pkg::ISSUE_WIDTH-1:0] dec_valid,
    input  core_pkg::decode_data_t            dec_data [issue_pkg::ISSUE_WIDTH],
    output logic                              dec_ready,
    input  logic                              flush,
    input  logic                              stall,
    input  logic [issue_pkg::WB_PORTS-1:0]    wb_en,
    input  core_pkg::reg_addr_t               wb_addr [issue_pkg::WB_PORTS],
    input  core_pkg::word_t                   wb_data [issue_pkg::WB_PORTS],
    output logic [issue_pkg::ISSUE_WIDTH-1:0] iss_valid,
    output core_pkg::issue_data_t             iss_data [issue_pkg::ISSUE_WIDTH]
);
    import core_pkg::*;
    import issue_pkg::*;

    decode_if dec_bus ();
    head_if   hd_bus ();

    // selector to register file
    reg_addr_t              rf_raddr [READ_PORTS];
    word_t                  rf_rdata [READ_PORTS];
    logic [READ_PORTS-1:0]  rf_ready;
    logic [ISSUE_WIDTH-1:0] set_en;
    reg_addr_t              set_addr [ISSUE_WIDTH];

    assign dec_bus.valid = dec_valid;
    assign dec_bus.data  = dec_data;
    assign dec_bus.flush = flush;
    assign dec_ready     = dec_bus.ready;
    assign hd_bus.flush  = flush;

    issue_queue u_queue (
        .clk    (clk),
        .arst_n (arst_n),
        .dec    (dec_bus),
        .hd     (hd_bus)
    );

    issue_select u_select (
        .clk       (clk),
        .arst_n    (arst_n),
        .hd        (hd_bus),
        .stall     (stall),
        .rf_raddr  (rf_raddr),
        .rf_rdata  (rf_rdata),
        .rf_ready  (rf_ready),
        .set_en    (set_en),
        .set_addr  (set_addr),
        .iss_valid (iss_valid),
        .iss_data  (iss_data)
    );

    register_file u_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .raddr    (rf_raddr),
        .rdata    (rf_rdata),
        .ready    (rf_ready),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .set_en   (set_en),
        .set_addr (set_addr),
        .flush    (flush)
    );

endmodule

/* test/issue_stage_sva.sv */
`timescale 1ns/1ps

module issue_stage_sva (
    input logic                              clk,
    input logic                              arst_n,
    input logic                              dec_ready,
    input issue_pkg::ptr_t                   tail,
    input logic                              stall,
    input logic                              flush,
    input logic [issue_pkg::ISSUE_WIDTH-1:0] iss_valid
);

    // tail moves only when the queue takes a pair
    no_push_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        (!dec_ready && !flush) |=> $stable(tail))
        else $error("queue tail moved while dec_ready low");

    // slot 1 never alone
    slot1_needs_slot0: assert property (@(posedge clk) disable iff (!arst_n)
        iss_valid[1] |-> iss_valid[0])
        else $error("iss_valid[1] without iss_valid[0]");

    // nothing new leaves during stall
    quiet_in_stall: assert property (@(posedge clk) disable iff (!arst_n)
        (stall && (iss_valid == '0)) |=> (iss_valid == '0))
        else $error("issue during stall");

    quiet_after_flush: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> (iss_valid == '0))
        else $error("issue in the cycle after flush");

    // reset leaves the stage empty and open
    quiet_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> ((iss_valid == '0) && dec_ready))
        else $error("outputs not idle after reset");

endmodule

bind issue_stage issue_stage_sva u_sva (
    .clk       (clk),
    .arst_n    (arst_n),
    .dec_ready (dec_ready),
    .tail      (u_queue.tail_ptr),
    .stall     (stall),
    .flush     (flush),
    .iss_valid (iss_valid)
);

/* test/tb_issue_stage.sv */
`timescale 1ns/1ps

module tb_issue_stage;
    import core_pkg::*;
    import issue_pkg::*;

    // well above the few hundred cycles the six tests need
    localparam int MAX_CYCLES  = 2000;
    localparam int IDLE_CYCLES = 6;

    // one issued instruction as seen at the outputs
    typedef struct packed {
        word_t       pc;
        word_t       raw_instr;
        word_t       imm;
        reg_addr_t   rdst;
        ctl_t        ctl;
        word_t       rd1;
        word_t       rd2;
        logic        valid;
        logic        slot;
        logic        lane;
        logic [15:0] cyc;
    } obs_t;

    logic                   clk;
    logic                   arst_n;
    logic [ISSUE_WIDTH-1:0] dec_valid;
    decode_data_t           dec_data [ISSUE_WIDTH];
    logic                   dec_ready;
    logic                   flush;
    logic                   stall;
    logic [WB_PORTS-1:0]    wb_en;
    reg_addr_t              wb_addr [WB_PORTS];
    word_t                  wb_data [WB_PORTS];
    logic [ISSUE_WIDTH-1:0] iss_valid;
    issue_data_t            iss_data [ISSUE_WIDTH];

    // reference register contents
    word_t       model_regs [NUM_REGS];
    obs_t        exp_q [$];
    obs_t        got_q [$];
    logic [15:0] lfsr;
    word_t       next_pc;
    int          cycle;
    int          errors;
    int          checks;
    int          tests;
    int          err_base;

    issue_stage UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .dec_valid (dec_valid),
        .dec_data  (dec_data),
        .dec_ready (dec_ready),
        .flush     (flush),
        .stall     (stall),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .iss_valid (iss_valid),
        .iss_data  (iss_data)
    );

    always #20 clk = ~clk;

    // rising edge count and run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout, tests did not end within %0d cycles", cycle);
            $display("Finished with errors");
            $finish;
        end
    end

    // registered outputs are stable at the falling edge
    always @(negedge clk) begin
        obs_t o;
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            if (arst_n && iss_valid[s]) begin
                o.pc        = iss_data[s].pc;
                o.raw_instr = iss_data[s].raw_instr;
                o.imm       = iss_data[s].imm;
                o.rdst      = iss_data[s].rdst;
                o.ctl       = iss_data[s].ctl;
                o.rd1       = iss_data[s].rd1;
                o.rd2       = iss_data[s].rd2;
                o.valid     = iss_data[s].valid;
                o.slot      = iss_data[s].is_slot;
                o.lane      = 1'(s);
                o.cyc       = 16'(cycle);
                got_q.push_back(o);
            end
        end
    end

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // fibonacci lfsr x^16+x^14+x^13+x^11 stepped once per bit
    function automatic word_t rand_word();
        word_t w;
        logic  fb;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            w    = {w[30:0], fb};
        end
        return w;
    endfunction

    // decoded instruction with control bits from its op class
    function automatic decode_data_t make_instr(input op_t op, input reg_addr_t ra1,
                                                input reg_addr_t ra2, input reg_addr_t rdst);
        decode_data_t d;
        d              = '0;
        d.valid        = 1'b1;
        d.pc           = next_pc;
        d.raw_instr    = {4'(op), 7'd0, ra1, ra2, rdst, 6'd0};
        d.imm          = next_pc >> 2;
        d.ra1          = ra1;
        d.ra2          = ra2;
        d.rdst         = rdst;
        d.ctl.op       = op;
        d.ctl.regwrite = (op inside {ALU, MFHI, MFLO}) && (rdst != '0);
        d.ctl.hiwrite  = op inside {MULT, DIV, MTHI};
        d.ctl.lowrite  = op inside {MULT, DIV, MTLO};
        d.ctl.hitoreg  = (op == MFHI);
        d.ctl.lotoreg  = (op == MFLO);
        d.ctl.branch   = (op == BRANCH);
        d.ctl.jump     = (op == JUMP);
        next_pc        = next_pc + 32'd4;
        return d;
    endfunction

    // cyc 0 leaves the issue cycle unchecked
    task automatic expect_issue(input decode_data_t d, input logic lane, input logic slot,
                                input int cyc);
        obs_t o;
        o.pc        = d.pc;
        o.raw_instr = d.raw_instr;
        o.imm       = d.imm;
        o.rdst      = d.rdst;
        o.ctl       = d.ctl;
        o.rd1       = model_regs[d.ra1];
        o.rd2       = model_regs[d.ra2];
        o.valid     = 1'b1;
        o.slot      = slot;
        o.lane      = lane;
        o.cyc       = 16'(cyc);
        exp_q.push_back(o);
    endtask

    // holds the pair until ready and returns the accepting edge in acc
    task automatic push_pair(input decode_data_t d0, input decode_data_t d1, input logic two,
                             output int acc);
        dec_data[0] = d0;
        dec_data[1] = d1;
        dec_valid   = {two, 1'b1};
        while (!dec_ready) begin
            @(negedge clk);
        end
        acc = cycle + 1;
        @(negedge clk);
        dec_valid = '0;
    endtask

    // writes fresh values through the writeback ports and returns the write edge
    task automatic wb_write(input reg_addr_t a0, input reg_addr_t a1, input logic two,
                            output int edge_no);
        word_t v0;
        word_t v1;
        v0         = rand_word();
        v1         = rand_word();
        wb_en      = {two, 1'b1};
        wb_addr[0] = a0;
        wb_addr[1] = a1;
        wb_data[0] = v0;
        wb_data[1] = v1;
        if (a0 != '0) begin
            model_regs[a0] = v0;
        end
        if (two && (a1 != '0)) begin
            model_regs[a1] = v1;
        end
        edge_no = cycle + 1;
        @(negedge clk);
        wb_en = '0;
    endtask

    task automatic wait_issued(input int n);
        while (got_q.size() < n) begin
            @(negedge clk);
        end
    endtask

    // compare everything issued against the expected order
    task automatic finish_test(input string name);
        int n;
        wait_issued(exp_q.size());
        repeat (IDLE_CYCLES) @(negedge clk);
        check_eq(got_q.size(), exp_q.size(), {name, " issue count"});
        n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
        for (int i = 0; i < n; i++) begin
            check_eq(got_q[i].pc, exp_q[i].pc, $sformatf("%s pc of #%0d", name, i));
            check_eq(got_q[i].raw_instr, exp_q[i].raw_instr,
                     $sformatf("%s raw_instr of #%0d", name, i));
            check_eq(got_q[i].imm, exp_q[i].imm, $sformatf("%s imm of #%0d", name, i));
            check_eq(got_q[i].rdst, exp_q[i].rdst, $sformatf("%s rdst of #%0d", name, i));
            check_eq(got_q[i].ctl, exp_q[i].ctl, $sformatf("%s ctl of #%0d", name, i));
            check_eq(got_q[i].rd1, exp_q[i].rd1, $sformatf("%s rd1 of #%0d", name, i));
            check_eq(got_q[i].rd2, exp_q[i].rd2, $sformatf("%s rd2 of #%0d", name, i));
            check_eq(got_q[i].valid, exp_q[i].valid, $sformatf("%s valid of #%0d", name, i));
            check_eq(got_q[i].slot, exp_q[i].slot, $sformatf("%s is_slot of #%0d", name, i));
            check_eq(got_q[i].lane, exp_q[i].lane, $sformatf("%s lane of #%0d", name, i));
            if (exp_q[i].cyc != '0) begin
                check_eq(got_q[i].cyc, exp_q[i].cyc, $sformatf("%s cycle of #%0d", name, i));
            end
        end
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - err_base);
        err_base = errors;
        got_q.delete();
        exp_q.delete();
    endtask

    task automatic independent_pair();
        decode_data_t a;
        decode_data_t b;
        int           acc;
        int           w;
        a = make_instr(ALU, 5'd1, 5'd2, 5'd3);
        b = make_instr(ALU, 5'd4, 5'd5, 5'd6);
        push_pair(a, b, 1'b1, acc);
        expect_issue(a, 1'b0, 1'b0, acc + 1);
        expect_issue(b, 1'b1, 1'b0, acc + 1);
        finish_test("independent alu pair");
        wb_write(5'd3, 5'd6, 1'b1, w);
    endtask

    task automatic pairing_hazards();
        decode_data_t a;
        decode_data_t b;
        int           acc;
        int           w;
        // read after write inside the pair
        a = make_instr(ALU, 5'd1, 5'd2, 5'd7);
        b = make_instr(ALU, 5'd7, 5'd2, 5'd8);
        push_pair(a, b, 1'b1, acc);
        expect_issue(a, 1'b0, 1'b0, acc + 1);
        wait_issued(1);
        wb_write(5'd7, 5'd0, 1'b0, w);
        expect_issue(b, 1'b0, 1'b0, w);
        wait_issued(2);
        // one mul/div unit
        a = make_instr(MULT, 5'd9, 5'd10, 5'd0);
        b = make_instr(DIV, 5'd11, 5'd12, 5'd0);
        push_pair(a, b, 1'b1, acc);
        expect_issue(a, 1'b0, 1'b0, acc + 1);
        expect_issue(b, 1'b0, 1'b0, acc + 2);
        finish_test("pairing hazards");
        wb_write(5'd8, 5'd0, 1'b0, w);
    endtask

    task automatic scoreboard_wait();
        decode_data_t a;
        decode_data_t b;
        int           acc;
        int           w;
        a = make_instr(ALU, 5'd1, 5'd2, 5'd13);
        b = make_instr(ALU, 5'd13, 5'd14, 5'd15);
        push_pair(a, a, 1'b0, acc);
        expect_issue(a, 1'b0, 1'b0, acc + 1);
        wait_issued(1);
        push_pair(b, b, 1'b0, acc);
        repeat (5) @(negedge clk);
        check_eq(got_q.size(), 1, "consumer withheld while r13 pending");
        // write-through lets the consumer go at the write edge
        wb_write(5'd13, 5'd0, 1'b0, w);
        expect_issue(b, 1'b0, 1'b0, w);
        finish_test("scoreboard");
        wb_write(5'd15, 5'd0, 1'b0, w);
    endtask

    task automatic branch_delay_slot();
        decode_data_t a;
        decode_data_t b;
        int           acc;
        int           w;
        a = make_instr(BRANCH, 5'd1, 5'd2, 5'd0);
        b = make_instr(ALU, 5'd3, 5'd4, 5'd16);
        push_pair(a, b, 1'b1, acc);
        expect_issue(a, 1'b0, 1'b0, acc + 1);
        expect_issue(b, 1'b1, 1'b1, acc + 1);
        wait_issued(2);
        // jump alone waits for its slot
        a = make_instr(JUMP, 5'd5, 5'd0, 5'd0);
        b = make_instr(ALU, 5'd6, 5'd7, 5'd17);
        push_pair(a, a, 1'b0, acc);
        repeat (5) @(negedge clk);
        check_eq(got_q.size(), 2, "jump issued without delay slot");
        push_pair(b, b, 1'b0, acc);
        expect_issue(a, 1'b0, 1'b0, acc + 1);
        expect_issue(b, 1'b1, 1'b1, acc + 1);
        finish_test("branch delay slot");
        wb_write(5'd16, 5'd17, 1'b1, w);
    endtask

    task automatic back_pressure();
        decode_data_t a;
        decode_data_t b;
        int           acc;
        stall = 1'b1;
        for (int i = 0; i < QUEUE_DEPTH / 2; i++) begin
            a = make_instr(ALU, reg_addr_t'(i + 1), reg_addr_t'(i + 9), 5'd0);
            b = make_instr(ALU, reg_addr_t'(i + 17), reg_addr_t'(i + 2), 5'd0);
            push_pair(a, b, 1'b1, acc);
            expect_issue(a, 1'b0, 1'b0, 0);
            expect_issue(b, 1'b1, 1'b0, 0);
        end
        check_eq(dec_ready, 1'b0, "dec_ready with 16 entries");
        check_eq(got_q.size(), 0, "issues during stall");
        // decode holds the next pair while ready is low
        a = make_instr(ALU, 5'd30, 5'd31, 5'd0);
        b = make_instr(ALU, 5'd29, 5'd28, 5'd0);
        dec_data[0] = a;
        dec_data[1] = b;
        dec_valid   = 2'b11;
        repeat (3) @(negedge clk);
        stall = 1'b0;
        while (!dec_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        dec_valid = '0;
        expect_issue(a, 1'b0, 1'b0, 0);
        expect_issue(b, 1'b1, 1'b0, 0);
        finish_test("back-pressure");
    endtask

    task automatic flush_queue();
        decode_data_t a;
        decode_data_t b;
        int           acc;
        a = make_instr(ALU, 5'd1, 5'd2, 5'd20);
        push_pair(a, a, 1'b0, acc);
        expect_issue(a, 1'b0, 1'b0, acc + 1);
        wait_issued(1);
        // head blocked on r20 with two pairs queued behind it
        a = make_instr(ALU, 5'd20, 5'd3, 5'd21);
        b = make_instr(ALU, 5'd4, 5'd5, 5'd22);
        push_pair(a, b, 1'b1, acc);
        a = make_instr(ALU, 5'd6, 5'd7, 5'd0);
        b = make_instr(ALU, 5'd8, 5'd9, 5'd0);
        push_pair(a, b, 1'b1, acc);
        repeat (2) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        repeat (4) @(negedge clk);
        check_eq(got_q.size(), 1, "flushed entries issued");
        // r20 no longer pending and keeps its old value
        a = make_instr(ALU, 5'd20, 5'd6, 5'd23);
        push_pair(a, a, 1'b0, acc);
        expect_issue(a, 1'b0, 1'b0, acc + 1);
        finish_test("flush");
    endtask

    initial begin
        int w;
        clk       = 1'b0;
        arst_n    = 1'b0;
        dec_valid = '0;
        flush     = 1'b0;
        stall     = 1'b0;
        wb_en     = '0;
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            dec_data[s] = '0;
        end
        for (int p = 0; p < WB_PORTS; p++) begin
            wb_addr[p] = '0;
            wb_data[p] = '0;
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        lfsr     = 16'd28433;
        next_pc  = 32'h0040_0000;
        cycle    = 0;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        err_base = 0;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        // preload r1..r31 two at a time
        for (int r = 1; r < NUM_REGS; r += 2) begin
            wb_write(reg_addr_t'(r), reg_addr_t'(r + 1), (r + 1) < NUM_REGS, w);
        end
        independent_pair();
        pairing_hazards();
        scoreboard_wait();
        branch_delay_slot();
        back_pressure();
        flush_queue();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* all.f */
src/core_pkg.sv
src/issue_pkg.sv
src/issue_if.sv
src/issue_queue.sv
src/issue_select.sv
src/register_file.sv
src/issue_stage.sv
test/issue_stage_sva.sv
test/tb_issue_stage.sv

/* Makefile */
TOP = tb_issue_stage

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f src/*.sv test/*.sv
	verilator --binary --assert -Wno-fatal -f all.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

lint:
	verilator --lint-only --timing --assert -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir
